// ==== files.f ====
rtl/noc_pkg.sv
rtl/req_sync.sv
rtl/rx_port.sv
rtl/route_table.sv
rtl/crossbar_switch.sv
rtl/tx_port.sv
rtl/noc_router.sv
sim/noc_router_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module noc_router_tb \
	-f files.f \
	-o noc_router_sim

./obj_dir/noc_router_sim | tee sim.log

if grep -q "TEST PASS" sim.log; then
	exit 0
else
	exit 1
fi

// ==== sim/noc_router_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module noc_router_tb;

	import noc_pkg::*;

	localparam int NUM_ROWS = 11;
	localparam int FLITS = 8;
	// generous bound per packet covering slow acks, sync and contention
	localparam int PACKET_NS = 400 * 40;
	localparam int WATCHDOG_NS = NUM_ROWS * 2 * PACKET_NS + 2000;

	// one packet of a row with its expected fate
	typedef struct packed {
		logic       en;
		logic       src;
		logic [1:0] dest;
		logic       drop;
		logic       out;
	} pkt_t;

	typedef struct packed {
		route_entry_t [3:0] routes;
		pkt_t [1:0]         pkts;
	} row_t;

	logic               clk;
	logic               reset;
	logic [1:0]         in_req;
	logic [7:0]         in_flit [2];
	logic [1:0]         in_ack;
	logic [1:0]         out_req;
	logic [7:0]         out_flit [2];
	logic [1:0]         out_ack;
	logic               cfg_we;
	logic [1:0]         cfg_addr;
	route_entry_t       cfg_entry;

	row_t               rows [NUM_ROWS];
	int                 row_fill = 0;
	logic [7:0]         pkt_flits [2][FLITS];
	logic [7:0]         rcv_mem [2][32];
	int                 rcv_cnt [2];
	int                 delivered [2];
	int                 last_winner [2];
	bit                 last_valid [2];
	int                 errors = 0;
	int                 checks = 0;
	logic [31:0]        lfsr = 32'h1a0ea044;

	noc_router noc_router_i (
		.clk       (clk),
		.reset     (reset),
		.in_req    (in_req),
		.in_flit   (in_flit),
		.in_ack    (in_ack),
		.out_req   (out_req),
		.out_flit  (out_flit),
		.out_ack   (out_ack),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_entry (cfg_entry)
	);

	always #20 clk = ~clk;

	// galois lfsr stepped once per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic pkt_t make_pkt(input bit en, input bit src, input bit [1:0] dest,
		input bit drop, input bit out);
		return '{en, src, dest, drop, out};
	endfunction

	task automatic add_row(input logic [7:0] routes, input pkt_t a, input pkt_t b);
		rows[row_fill].routes  = routes;
		rows[row_fill].pkts[0] = a;
		rows[row_fill].pkts[1] = b;
		row_fill++;
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("** Error: %s = %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic program_routes(input route_entry_t [3:0] routes);
		for (int d = 0; d < 4; d++) begin
			@(negedge clk);
			cfg_we    = 1'b1;
			cfg_addr  = d[1:0];
			cfg_entry = routes[d];
		end
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	// only the head has the flag set and carries the destination
	task automatic build_flits(input bit src, input bit [1:0] dest);
		logic [31:0] b;
		b = rand_bits(5);
		pkt_flits[src][0] = {1'b1, b[4:0], dest};
		for (int f = 1; f < FLITS; f++) begin
			b = rand_bits(7);
			pkt_flits[src][f] = {1'b0, b[6:0]};
		end
	endtask

	task automatic send_packet(input pkt_t p);
		for (int f = 0; f < FLITS; f++) begin
			@(negedge clk);
			in_flit[p.src] = pkt_flits[p.src][f];
			in_req[p.src]  = ~in_req[p.src];
			while (in_ack[p.src] != in_req[p.src]) begin
				@(negedge clk);
			end
		end
		// final ack only once the receiver has taken the last flit
		if (!p.drop) begin
			delivered[p.out]++;
			check_value($sformatf("out_req[%0d] toggles at final in_ack[%0d]", p.out, p.src),
				rcv_cnt[p.out], delivered[p.out] * FLITS);
			check_value($sformatf("out_ack[%0d] at final in_ack[%0d]", p.out, p.src),
				out_ack[p.out], out_req[p.out]);
		end
	endtask

	task automatic check_outputs(input row_t row);
		int order [2];
		int n;
		int tmp;
		int src;
		for (int j = 0; j < 2; j++) begin
			n = 0;
			for (int p = 0; p < 2; p++) begin
				if (row.pkts[p].en && !row.pkts[p].drop && row.pkts[p].out == j[0]) begin
					order[n] = p;
					n++;
				end
			end
			check_value($sformatf("out_req[%0d] toggle count", j), rcv_cnt[j], n * FLITS);
			if (n == 2) begin
				// whichever head came out first owns the first packet slot
				if (rcv_mem[j][0] == pkt_flits[row.pkts[order[1]].src][0]) begin
					tmp      = order[0];
					order[0] = order[1];
					order[1] = tmp;
				end
				src = row.pkts[order[0]].src;
				// round robin serves the input that did not get this output last
				if (last_valid[j]) begin
					check_value($sformatf("first winner on out %0d", j), src,
						1 - last_winner[j]);
				end
			end
			if (n > 0) begin
				last_winner[j] = row.pkts[order[n - 1]].src;
				last_valid[j]  = 1'b1;
			end
			for (int q = 0; q < n; q++) begin
				src = row.pkts[order[q]].src;
				for (int f = 0; f < FLITS; f++) begin
					if (q * FLITS + f < rcv_cnt[j]) begin
						check_value($sformatf("out_flit[%0d] flit %0d", j, q * FLITS + f),
							rcv_mem[j][q * FLITS + f], pkt_flits[src][f]);
					end
				end
			end
		end
	endtask

	// receiver per output with a random ack delay of 0 to 15 cycles
	for (genvar j = 0; j < 2; j++) begin : g_rcv
		initial begin
			logic [31:0] delay;
			forever begin
				@(negedge clk);
				if (!reset && out_req[j] != out_ack[j]) begin
					if (rcv_cnt[j] < 32) begin
						rcv_mem[j][rcv_cnt[j]] = out_flit[j];
					end
					rcv_cnt[j]++;
					delay = rand_bits(4);
					repeat (delay) @(negedge clk);
					out_ack[j] = ~out_ack[j];
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int row_start;
		clk       = 1'b0;
		reset     = 1'b1;
		in_req    = '0;
		in_flit   = '{default: '0};
		out_ack   = '0;
		cfg_we    = 1'b0;
		cfg_addr  = '0;
		cfg_entry = '0;
		rcv_cnt   = '{default: 0};
		delivered = '{default: 0};
		last_valid = '{default: 1'b0};

		// routes packed as {d3 d2 d1 d0} with each entry {valid port}
		add_row(8'b11_00_11_10, make_pkt(1, 0, 0, 0, 0), make_pkt(0, 0, 0, 0, 0));
		add_row(8'b11_00_11_10, make_pkt(1, 1, 1, 0, 1), make_pkt(0, 0, 0, 0, 0));
		add_row(8'b11_00_11_10, make_pkt(1, 0, 2, 1, 0), make_pkt(0, 0, 0, 0, 0));
		add_row(8'b11_00_11_10, make_pkt(1, 1, 2, 1, 0), make_pkt(1, 0, 3, 0, 1));
		add_row(8'b11_00_11_10, make_pkt(1, 0, 1, 0, 1), make_pkt(1, 1, 0, 0, 0));
		// repeated contention for out 1
		add_row(8'b11_00_11_10, make_pkt(1, 0, 1, 0, 1), make_pkt(1, 1, 3, 0, 1));
		add_row(8'b11_00_11_10, make_pkt(1, 0, 1, 0, 1), make_pkt(1, 1, 3, 0, 1));
		add_row(8'b11_00_11_10, make_pkt(1, 0, 1, 0, 1), make_pkt(1, 1, 3, 0, 1));
		add_row(8'b11_00_11_10, make_pkt(1, 0, 1, 0, 1), make_pkt(1, 1, 3, 0, 1));
		add_row(8'b11_10_11_10, make_pkt(1, 1, 2, 0, 0), make_pkt(1, 0, 0, 0, 0));
		add_row(8'b11_10_11_00, make_pkt(1, 0, 0, 1, 0), make_pkt(1, 1, 2, 0, 0));

		repeat (10) @(negedge clk);
		reset = 1'b0;

		// idle outputs after reset
		row_start = errors;
		repeat (5) begin
			@(negedge clk);
			check_value("in_ack", in_ack, 0);
			check_value("out_req", out_req, 0);
			check_value("out_flit[0]", out_flit[0], 0);
			check_value("out_flit[1]", out_flit[1], 0);
		end
		$display("reset state: %s", (errors == row_start) ? "ok" : "failed");

		for (int r = 0; r < NUM_ROWS; r++) begin
			row_start = errors;
			program_routes(rows[r].routes);
			for (int p = 0; p < 2; p++) begin
				if (rows[r].pkts[p].en) begin
					build_flits(rows[r].pkts[p].src, rows[r].pkts[p].dest);
				end
			end
			rcv_cnt   = '{default: 0};
			delivered = '{default: 0};
			fork
				begin
					if (rows[r].pkts[0].en) send_packet(rows[r].pkts[0]);
				end
				begin
					if (rows[r].pkts[1].en) send_packet(rows[r].pkts[1]);
				end
			join
			repeat (4) @(negedge clk);
			check_outputs(rows[r]);
			$display("row %0d: %s", r, (errors == row_start) ? "ok" : "failed");
		end

		$display("%0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/noc_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module noc_router #(
	parameter int NUM_PORTS = noc_pkg::NUM_PORTS,
	parameter int FLIT_BITS = noc_pkg::FLIT_BITS,
	parameter int BUFF_BITS = noc_pkg::BUFF_BITS,
	parameter int DEST_BITS = noc_pkg::DEST_BITS,
	parameter int PORT_BITS = noc_pkg::PORT_BITS
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [NUM_PORTS-1:0]  in_req,
	input  logic [FLIT_BITS-1:0]  in_flit [NUM_PORTS],
	output logic [NUM_PORTS-1:0]  in_ack,
	output logic [NUM_PORTS-1:0]  out_req,
	output logic [FLIT_BITS-1:0]  out_flit [NUM_PORTS],
	input  logic [NUM_PORTS-1:0]  out_ack,
	input  logic                  cfg_we,
	input  logic [DEST_BITS-1:0]  cfg_addr,
	input  noc_pkg::route_entry_t cfg_entry
);

	import noc_pkg::*;

	logic [DEST_BITS-1:0] table_addr [NUM_PORTS];
	route_entry_t         table_entry [NUM_PORTS];
	logic [NUM_PORTS-1:0] sw_req;
	logic [PORT_BITS-1:0] sw_port [NUM_PORTS];
	logic [NUM_PORTS-1:0] sw_gnt;
	logic [BUFF_BITS-1:0] buf_addr [NUM_PORTS];
	logic [FLIT_BITS-1:0] buf_data [NUM_PORTS];
	logic [NUM_PORTS-1:0] tx_start;
	logic [NUM_PORTS-1:0] tx_busy;
	logic [BUFF_BITS-1:0] rd_addr [NUM_PORTS];
	logic [FLIT_BITS-1:0] rd_data [NUM_PORTS];

	for (genvar k = 0; k < NUM_PORTS; k++) begin : g_rx
		rx_port #(
			.FLIT_BITS (FLIT_BITS),
			.BUFF_BITS (BUFF_BITS),
			.DEST_BITS (DEST_BITS),
			.PORT_BITS (PORT_BITS)
		) rx_port_i (
			.clk         (clk),
			.reset       (reset),
			.ch_req      (in_req[k]),
			.ch_flit     (in_flit[k]),
			.ch_ack      (in_ack[k]),
			.table_addr  (table_addr[k]),
			.table_entry (table_entry[k]),
			.sw_req      (sw_req[k]),
			.sw_port     (sw_port[k]),
			.sw_gnt      (sw_gnt[k]),
			.buf_addr    (buf_addr[k]),
			.buf_data    (buf_data[k])
		);
	end

	route_table #(
		.DEST_BITS (DEST_BITS),
		.PORT_BITS (PORT_BITS),
		.NUM_PORTS (NUM_PORTS)
	) route_table_i (
		.clk          (clk),
		.reset        (reset),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_entry    (cfg_entry),
		.lookup_addr  (table_addr),
		.lookup_entry (table_entry)
	);

	crossbar_switch #(
		.NUM_PORTS (NUM_PORTS),
		.BUFF_BITS (BUFF_BITS),
		.FLIT_BITS (FLIT_BITS),
		.PORT_BITS (PORT_BITS)
	) crossbar_switch_i (
		.clk      (clk),
		.reset    (reset),
		.sw_req   (sw_req),
		.sw_port  (sw_port),
		.sw_gnt   (sw_gnt),
		.buf_addr (buf_addr),
		.buf_data (buf_data),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	for (genvar j = 0; j < NUM_PORTS; j++) begin : g_tx
		tx_port #(
			.FLIT_BITS (FLIT_BITS),
			.BUFF_BITS (BUFF_BITS)
		) tx_port_i (
			.clk      (clk),
			.reset    (reset),
			.tx_start (tx_start[j]),
			.tx_busy  (tx_busy[j]),
			.rd_addr  (rd_addr[j]),
			.rd_data  (rd_data[j]),
			.ch_req   (out_req[j]),
			.ch_flit  (out_flit[j]),
			.ch_ack   (out_ack[j])
		);
	end

endmodule

`default_nettype wire

// ==== rtl/tx_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_port #(
	parameter int FLIT_BITS = noc_pkg::FLIT_BITS,
	parameter int BUFF_BITS = noc_pkg::BUFF_BITS
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tx_start,
	output logic                 tx_busy,
	output logic [BUFF_BITS-1:0] rd_addr,
	input  logic [FLIT_BITS-1:0] rd_data,
	output logic                 ch_req,
	output logic [FLIT_BITS-1:0] ch_flit,
	input  logic                 ch_ack
);

	import noc_pkg::*;

	tx_state_t            state;
	logic [FLIT_BITS-1:0] flit_q;
	logic                 ack_pulse;

	req_sync ack_sync_i (
		.clk   (clk),
		.reset (reset),
		.req   (ch_ack),
		.pulse (ack_pulse)
	);

	// buffer read goes through the switch, register it first
	always_ff @(posedge clk) begin
		if (state == tx_read) begin
			flit_q <= rd_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state   <= tx_idle;
			tx_busy <= 1'b0;
			rd_addr <= '0;
			ch_req  <= 1'b0;
			ch_flit <= '0;
		end else begin
			case (state)
				tx_idle: begin
					if (tx_start) begin
						tx_busy <= 1'b1;
						rd_addr <= '0;
						state   <= tx_read;
					end
				end
				tx_read: begin
					state <= tx_send;
				end
				tx_send: begin
					// data and request change on the same edge
					ch_flit <= flit_q;
					ch_req  <= ~ch_req;
					state   <= tx_wait_ack;
				end
				tx_wait_ack: begin
					if (ack_pulse) begin
						if (&rd_addr) begin
							tx_busy <= 1'b0;
							state   <= tx_idle;
						end else begin
							rd_addr <= rd_addr + 1'b1;
							state   <= tx_read;
						end
					end
				end
				default: begin
					state <= tx_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/crossbar_switch.sv ====
`timescale 1ns/100ps
`default_nettype none

module crossbar_switch #(
	parameter int NUM_PORTS = noc_pkg::NUM_PORTS,
	parameter int BUFF_BITS = noc_pkg::BUFF_BITS,
	parameter int FLIT_BITS = noc_pkg::FLIT_BITS,
	parameter int PORT_BITS = noc_pkg::PORT_BITS
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_PORTS-1:0] sw_req,
	input  logic [PORT_BITS-1:0] sw_port [NUM_PORTS],
	output logic [NUM_PORTS-1:0] sw_gnt,
	output logic [BUFF_BITS-1:0] buf_addr [NUM_PORTS],
	input  logic [FLIT_BITS-1:0] buf_data [NUM_PORTS],
	output logic [NUM_PORTS-1:0] tx_start,
	input  logic [NUM_PORTS-1:0] tx_busy,
	input  logic [BUFF_BITS-1:0] rd_addr [NUM_PORTS],
	output logic [FLIT_BITS-1:0] rd_data [NUM_PORTS]
);

	// per output: held grant, owning input, round-robin pointer
	logic [NUM_PORTS-1:0] held;
	logic [PORT_BITS-1:0] owner [NUM_PORTS];
	logic [PORT_BITS-1:0] ptr [NUM_PORTS];
	logic [NUM_PORTS-1:0] found;
	logic [PORT_BITS-1:0] winner [NUM_PORTS];

	// search from the pointer for the first input asking for this output
	always_comb begin
		int idx;
		for (int j = 0; j < NUM_PORTS; j++) begin
			found[j]  = 1'b0;
			winner[j] = '0;
			for (int off = 0; off < NUM_PORTS; off++) begin
				idx = (int'(ptr[j]) + off) % NUM_PORTS;
				if (!found[j] && sw_req[idx] && sw_port[idx] == PORT_BITS'(j)) begin
					found[j]  = 1'b1;
					winner[j] = PORT_BITS'(idx);
				end
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			held     <= '0;
			tx_start <= '0;
			for (int j = 0; j < NUM_PORTS; j++) begin
				owner[j] <= '0;
				ptr[j]   <= '0;
			end
		end else begin
			for (int j = 0; j < NUM_PORTS; j++) begin
				tx_start[j] <= 1'b0;
				if (!held[j]) begin
					if (found[j]) begin
						held[j]     <= 1'b1;
						owner[j]    <= winner[j];
						tx_start[j] <= 1'b1;
						ptr[j]      <= (int'(winner[j]) == NUM_PORTS - 1) ?
							'0 : winner[j] + 1'b1;
					end
				end else if (!tx_start[j] && !tx_busy[j]) begin
					// tx_busy is not up yet while tx_start is still pending
					held[j] <= 1'b0;
				end
			end
		end
	end

	// steer the read path between owner and output
	always_comb begin
		sw_gnt = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			buf_addr[i] = '0;
		end
		for (int j = 0; j < NUM_PORTS; j++) begin
			rd_data[j] = buf_data[owner[j]];
			if (held[j]) begin
				sw_gnt[owner[j]]   = 1'b1;
				buf_addr[owner[j]] = rd_addr[j];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/route_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module route_table #(
	parameter int DEST_BITS = noc_pkg::DEST_BITS,
	parameter int PORT_BITS = noc_pkg::PORT_BITS,
	parameter int NUM_PORTS = noc_pkg::NUM_PORTS
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cfg_we,
	input  logic [DEST_BITS-1:0]  cfg_addr,
	input  noc_pkg::route_entry_t cfg_entry,
	input  logic [DEST_BITS-1:0]  lookup_addr [NUM_PORTS],
	output noc_pkg::route_entry_t lookup_entry [NUM_PORTS]
);

	localparam int ENTRIES = 2 ** DEST_BITS;

	logic [ENTRIES-1:0]   valid_bits;
	logic [PORT_BITS-1:0] port_mem [ENTRIES];

	// every destination starts out unrouted
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (cfg_we) begin
			valid_bits[cfg_addr] <= cfg_entry.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_we) begin
			port_mem[cfg_addr] <= cfg_entry.port;
		end
	end

	// one read port per input
	always_comb begin
		for (int k = 0; k < NUM_PORTS; k++) begin
			lookup_entry[k].valid = valid_bits[lookup_addr[k]];
			lookup_entry[k].port  = port_mem[lookup_addr[k]];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rx_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_port #(
	parameter int FLIT_BITS = noc_pkg::FLIT_BITS,
	parameter int BUFF_BITS = noc_pkg::BUFF_BITS,
	parameter int DEST_BITS = noc_pkg::DEST_BITS,
	parameter int PORT_BITS = noc_pkg::PORT_BITS
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ch_req,
	input  logic [FLIT_BITS-1:0]  ch_flit,
	output logic                  ch_ack,
	output logic [DEST_BITS-1:0]  table_addr,
	input  noc_pkg::route_entry_t table_entry,
	output logic                  sw_req,
	output logic [PORT_BITS-1:0]  sw_port,
	input  logic                  sw_gnt,
	input  logic [BUFF_BITS-1:0]  buf_addr,
	output logic [FLIT_BITS-1:0]  buf_data
);

	import noc_pkg::*;

	localparam int FLITS = 2 ** BUFF_BITS;

	rx_state_t            state;
	route_entry_t         entry_q;
	logic [FLIT_BITS-1:0] flit_q;
	logic [BUFF_BITS-1:0] flit_count;
	logic [FLIT_BITS-1:0] buf_mem [FLITS];
	logic                 req_pulse;
	logic                 head_flit;
	logic                 last_flit;

	req_sync req_sync_i (
		.clk   (clk),
		.reset (reset),
		.req   (ch_req),
		.pulse (req_pulse)
	);

	assign head_flit = flit_q[FLIT_BITS-1];
	assign last_flit = &flit_count;

	// read side belongs to the switch
	assign buf_data = buf_mem[buf_addr];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state      <= rx_idle;
			entry_q    <= '0;
			flit_count <= '0;
			table_addr <= '0;
			sw_req     <= 1'b0;
			sw_port    <= '0;
			ch_ack     <= 1'b0;
			for (int i = 0; i < FLITS; i++) begin
				buf_mem[i] <= '0;
			end
		end else begin
			case (state)
				rx_idle: begin
					if (req_pulse) begin
						flit_q <= ch_flit;
						state  <= rx_latched;
					end
				end
				rx_latched: begin
					// only the head carries a destination
					if (head_flit) begin
						table_addr <= flit_q[DEST_BITS-1:0];
						state      <= rx_route;
					end else begin
						state <= rx_buffer;
					end
				end
				rx_route: begin
					entry_q <= table_entry;
					state   <= rx_buffer;
				end
				rx_buffer: begin
					buf_mem[flit_count] <= flit_q;
					flit_count          <= flit_count + 1'b1;
					if (!last_flit) begin
						ch_ack <= ~ch_ack;
						state  <= rx_idle;
					end else if (!entry_q.valid) begin
						// no route, packet is dropped here
						ch_ack     <= ~ch_ack;
						flit_count <= '0;
						state      <= rx_idle;
					end else begin
						sw_req  <= 1'b1;
						sw_port <= entry_q.port;
						state   <= rx_wait_grant;
					end
				end
				rx_wait_grant: begin
					if (sw_gnt) begin
						sw_req <= 1'b0;
						state  <= rx_send;
					end
				end
				rx_send: begin
					// grant falls once the output is done with the buffer
					if (!sw_gnt) begin
						ch_ack     <= ~ch_ack;
						flit_count <= '0;
						state      <= rx_idle;
					end
				end
				default: begin
					state <= rx_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/req_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module req_sync (
	input  logic clk,
	input  logic reset,
	input  logic req,
	output logic pulse
);

	logic sync_1;
	logic sync_2;
	logic sync_prev;

	// two flops against metastability, third keeps the last level seen
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_1    <= 1'b0;
			sync_2    <= 1'b0;
			sync_prev <= 1'b0;
		end else begin
			sync_1    <= req;
			sync_2    <= sync_1;
			sync_prev <= sync_2;
		end
	end

	// two-phase: rising and falling edges both count
	assign pulse = sync_2 ^ sync_prev;

endmodule

`default_nettype wire

// ==== rtl/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

	// defaults, overridden from the top level
	parameter int NUM_PORTS = 2;
	parameter int FLIT_BITS = 8;
	parameter int BUFF_BITS = 3;
	parameter int DEST_BITS = 2;
	parameter int PORT_BITS = 1;

	// one routing table entry
	// an invalid entry means packets to that destination are dropped
	typedef struct packed {
		logic                 valid;
		logic [PORT_BITS-1:0] port;
	} route_entry_t;

	// input port states
	typedef enum logic [2:0] {
		rx_idle       = 3'b000,
		rx_latched    = 3'b001,
		rx_route      = 3'b011,
		rx_buffer     = 3'b101,
		rx_wait_grant = 3'b100,
		rx_send       = 3'b111
	} rx_state_t;

	// output port states
	typedef enum logic [1:0] {
		tx_idle     = 2'b00,
		tx_read     = 2'b01,
		tx_send     = 2'b11,
		tx_wait_ack = 2'b10
	} tx_state_t;

endpackage

`default_nettype wire
